/* cam_pipeline.f */
design/cam_pkg.sv
design/frame_buffer.sv
design/frame_sequencer.sv
design/gray_filter.sv
design/edge_filter.sv
design/vga_scanout.sv
design/cam_pipeline_top.sv
verif/cam_pipeline_assertions.sv
verif/cam_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the camera pipeline testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cam_pipeline_tb \
    -f cam_pipeline.f -o cam_pipeline_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/cam_pipeline_sim +verilator+error+limit+1000 \
    | tee /dev/stderr \
    | grep -qx "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verif/cam_pipeline_tb.sv */
// Testbench for the camera frame pipeline
// Streams pixels, runs the gray and edge passes and checks the VGA frames
`timescale 1ns/1ps

module cam_pipeline_tb import cam_pkg::*; ();

    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NEW_PIXELS     = 64;

    logic     clk_25_vga;
    logic     reset_global;
    logic     process_sw;
    pixel_t   pix_in;
    logic     pix_valid;
    logic     pix_ready;
    vga_out_t vga;
    logic     frame_done;

    int          seed = 32'h38dbdb5c;
    int          errors = 0;
    int          assert_fails = 0;
    int          cycles = 0;
    int          frame_count;
    pixel_t      image [IMG_PIXELS];
    luma_t       gray_image [IMG_PIXELS];
    logic [23:0] frame [IMG_PIXELS];
    logic [23:0] expected [IMG_PIXELS];

    cam_pipeline_top cam_pipeline_top_i (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .process_sw   (process_sw),
        .pix_in       (pix_in),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .vga          (vga),
        .frame_done   (frame_done)
    );

    initial begin
        clk_25_vga = 1'b0;
        forever #10 clk_25_vga = ~clk_25_vga;
    end

    function automatic pixel_t draw_pixel();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    // Valid about three cycles out of four
    function automatic logic draw_valid();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    function automatic luma_t gray_of(pixel_t p);
        int sum;
        sum = int'(p.r) + 2 * int'(p.g) + int'(p.b);
        return luma_t'(sum / 4);
    endfunction

    // Gradient of the gray image with zero on the border
    function automatic luma_t edge_of(int a);
        int x;
        int y;
        int gh;
        int gv;
        x = a % IMG_W;
        y = a / IMG_W;
        if (x == 0 || x == IMG_W - 1 || y == 0 || y == IMG_H - 1) begin
            return 4'h0;
        end
        gh = int'(gray_image[a + 1]) - int'(gray_image[a - 1]);
        gv = int'(gray_image[a + IMG_W]) - int'(gray_image[a - IMG_W]);
        gh = (gh < 0) ? -gh : gh;
        gv = (gv < 0) ? -gv : gv;
        return (gh + gv > 15) ? 4'hF : luma_t'(gh + gv);
    endfunction

    function automatic logic [23:0] widen_colour(pixel_t p);
        return {p.r, p.r, p.g, p.g, p.b, p.b};
    endfunction

    function automatic logic [23:0] luma_colour(luma_t v);
        return {v, v, v, v, v, v};
    endfunction

    task automatic check_level(string test_name, string what, logic exp, logic act);
        assert (act == exp) else begin
            errors++;
            $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(string test_name);
        assert (frame_count == IMG_PIXELS) else begin
            errors++;
            $display("MISMATCH %s sample count expected %0d actual %0d",
                     test_name, IMG_PIXELS, frame_count);
        end
    endtask

    // Waits for the end of a vsync pulse, then keeps the active samples up to the next one
    task automatic capture_frame();
        frame_count = 0;
        @(negedge clk_25_vga);
        while (vga.vsync) @(negedge clk_25_vga);
        while (!vga.vsync) @(negedge clk_25_vga);
        while (vga.vsync) begin
            if (vga.blank_n) begin
                if (frame_count < IMG_PIXELS) begin
                    frame[frame_count] = {vga.r, vga.g, vga.b};
                end
                frame_count++;
            end
            @(negedge clk_25_vga);
        end
    endtask

    task automatic compare_frame(string test_name);
        int a;
        check_count(test_name);
        for (a = 0; a < IMG_PIXELS; a++) begin
            assert (frame[a] == expected[a]) else begin
                errors++;
                $display("MISMATCH %s addr %0d expected %h actual %h",
                         test_name, a, expected[a], frame[a]);
            end
        end
    endtask

    // Accepted pixels land in the model image from address 0 on
    task automatic stream_pixels(int count);
        int taken;
        taken = 0;
        @(posedge clk_25_vga);
        pix_in    <= draw_pixel();
        pix_valid <= draw_valid();
        while (taken < count) begin
            @(posedge clk_25_vga);
            if (pix_valid && pix_ready) begin
                image[taken] = pix_in;
                taken++;
                pix_in    <= draw_pixel();
                pix_valid <= (taken < count) && draw_valid();
            end else if (!pix_valid) begin
                pix_valid <= draw_valid();
            end
        end
        pix_valid <= 1'b0;
    endtask

    task automatic reset_state();
        @(posedge clk_25_vga);
        check_level("reset_state", "pix_ready", 1'b1, pix_ready);
        check_level("reset_state", "frame_done", 1'b0, frame_done);
        capture_frame();
        check_count("reset_state");
    endtask

    task automatic live_capture();
        int a;
        stream_pixels(IMG_PIXELS);
        capture_frame();
        for (a = 0; a < IMG_PIXELS; a++) begin
            expected[a] = widen_colour(image[a]);
        end
        compare_frame("live_capture");
        // A partial second frame leaves the ingest address away from 0
        stream_pixels(NEW_PIXELS);
    endtask

    // Pixels are offered on every cycle until the passes are done
    task automatic back_pressure();
        @(posedge clk_25_vga);
        process_sw <= 1'b1;
        @(posedge clk_25_vga);
        @(posedge clk_25_vga);
        check_level("back_pressure", "pix_ready", 1'b0, pix_ready);
        while (!frame_done) begin
            pix_valid <= 1'b1;
            pix_in    <= draw_pixel();
            @(posedge clk_25_vga);
            assert (!(pix_valid && pix_ready)) else begin
                errors++;
                $display("back_pressure: a pixel was accepted while processing");
            end
        end
        pix_valid <= 1'b0;
    endtask

    task automatic edge_result();
        int a;
        for (a = 0; a < IMG_PIXELS; a++) begin
            gray_image[a] = gray_of(image[a]);
        end
        for (a = 0; a < IMG_PIXELS; a++) begin
            expected[a] = luma_colour(edge_of(a));
        end
        @(posedge clk_25_vga);
        check_level("edge_result", "frame_done", 1'b1, frame_done);
        capture_frame();
        compare_frame("edge_result");
    endtask

    task automatic return_to_live();
        int a;
        @(posedge clk_25_vga);
        process_sw <= 1'b0;
        @(posedge clk_25_vga);
        @(posedge clk_25_vga);
        check_level("return_to_live", "frame_done", 1'b0, frame_done);
        check_level("return_to_live", "pix_ready", 1'b1, pix_ready);
        for (a = 0; a < IMG_PIXELS; a++) begin
            expected[a] = luma_colour(gray_image[a]);
        end
        capture_frame();
        compare_frame("return_to_live");
        // A short new stream must overwrite the gray image from address 0
        stream_pixels(NEW_PIXELS);
        for (a = 0; a < NEW_PIXELS; a++) begin
            expected[a] = widen_colour(image[a]);
        end
        capture_frame();
        compare_frame("return_to_live_restart");
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_25_vga);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset_global = 1'b1;
        process_sw   = 1'b0;
        pix_valid    = 1'b0;
        pix_in       = '0;
        repeat (RESET_CYCLES) @(posedge clk_25_vga);
        reset_global <= 1'b0;
        reset_state();
        live_capture();
        back_pressure();
        edge_result();
        return_to_live();
        assert_fails = cam_pipeline_top_i.cam_pipeline_assertions_i.fail_count;
        $display("Check errors: %0d, assertion errors: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verif/cam_pipeline_assertions.sv */
// Protocol and timing checks on the camera pipeline top level
// Watches the pixel handshake and VGA timing at the ports of cam_pipeline_top
`timescale 1ns/1ps

module cam_pipeline_assertions import cam_pkg::*; (
    input logic     clk_25_vga,
    input logic     reset_global,
    input logic     pix_ready,
    input logic     frame_done,
    input vga_out_t vga
);

    int fail_count = 0;

    // Ingest and hold are separate modes
    ready_vs_done: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        !(pix_ready && frame_done))
    else begin
        $error("pix_ready and frame_done are high together");
        fail_count++;
    end

    // Horizontal sync pulse is two cycles long
    hsync_min_width: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        $fell(vga.hsync) |=> !vga.hsync)
    else begin
        $error("hsync pulse shorter than two cycles");
        fail_count++;
    end

    hsync_max_width: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        (!vga.hsync && $past(vga.hsync) == 1'b0) |=> vga.hsync)
    else begin
        $error("hsync pulse longer than two cycles");
        fail_count++;
    end

    vsync_blanked: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        !vga.vsync |-> !vga.blank_n)
    else begin
        $error("blank_n high during the vsync pulse");
        fail_count++;
    end

    blank_is_black: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        !vga.blank_n |-> (vga.r == 8'h00 && vga.g == 8'h00 && vga.b == 8'h00))
    else begin
        $error("colour outputs not zero while blanked");
        fail_count++;
    end

endmodule

bind cam_pipeline_top cam_pipeline_assertions cam_pipeline_assertions_i (
    .clk_25_vga   (clk_25_vga),
    .reset_global (reset_global),
    .pix_ready    (pix_ready),
    .frame_done   (frame_done),
    .vga          (vga)
);

/* design/cam_pipeline_top.sv */
// Camera frame pipeline top level
// Live capture, gray and edge passes over two frame buffers, VGA display
`timescale 1ns/1ps

module cam_pipeline_top import cam_pkg::*; (
    input  logic     clk_25_vga,
    input  logic     reset_global,
    input  logic     process_sw,
    input  pixel_t   pix_in,
    input  logic     pix_valid,
    output logic     pix_ready,
    output vga_out_t vga,
    output logic     frame_done
);

    logic     gray_start;
    logic     gray_done;
    logic     edge_start;
    logic     edge_done;
    logic     show_edge;
    addr_t    gray_rd_addr;
    addr_t    edge_rd_addr;
    addr_t    scan_addr;
    addr_t    buf1_rd_addr;
    addr_t    buf2_rd_addr;
    pix_wr_t  gray_wr;
    pix_wr_t  buf1_wr;
    luma_wr_t edge_wr;
    luma_wr_t buf2_wr;
    pixel_t   buf1_rd_data;
    luma_t    buf2_rd_data;

    frame_sequencer frame_sequencer_i (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .process_sw   (process_sw),
        .frame_done   (frame_done),
        .pix_in       (pix_in),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .gray_start   (gray_start),
        .gray_done    (gray_done),
        .edge_start   (edge_start),
        .edge_done    (edge_done),
        .gray_rd_addr (gray_rd_addr),
        .gray_wr      (gray_wr),
        .edge_rd_addr (edge_rd_addr),
        .edge_wr      (edge_wr),
        .scan_addr    (scan_addr),
        .buf1_wr      (buf1_wr),
        .buf1_rd_addr (buf1_rd_addr),
        .buf2_wr      (buf2_wr),
        .show_edge    (show_edge)
    );

    gray_filter gray_filter_i (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .start        (gray_start),
        .done         (gray_done),
        .rd_addr      (gray_rd_addr),
        .rd_data      (buf1_rd_data),
        .wr           (gray_wr)
    );

    edge_filter edge_filter_i (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .start        (edge_start),
        .done         (edge_done),
        .rd_addr      (edge_rd_addr),
        .rd_data      (buf1_rd_data),
        .wr           (edge_wr)
    );

    // Buffer 1 holds RGB pixels, buffer 2 holds edge magnitudes
    frame_buffer #(.word_t(pixel_t)) frame_buf_1_i (
        .clk_25_vga (clk_25_vga),
        .wr_en      (buf1_wr.en),
        .wr_addr    (buf1_wr.addr),
        .wr_data    (buf1_wr.data),
        .rd_addr    (buf1_rd_addr),
        .rd_data    (buf1_rd_data)
    );

    frame_buffer #(.word_t(luma_t)) frame_buf_2_i (
        .clk_25_vga (clk_25_vga),
        .wr_en      (buf2_wr.en),
        .wr_addr    (buf2_wr.addr),
        .wr_data    (buf2_wr.data),
        .rd_addr    (buf2_rd_addr),
        .rd_data    (buf2_rd_data)
    );

    vga_scanout vga_scanout_i (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .show_edge    (show_edge),
        .scan_addr    (scan_addr),
        .buf1_data    (buf1_rd_data),
        .buf2_data    (buf2_rd_data),
        .buf2_rd_addr (buf2_rd_addr),
        .vga          (vga)
    );

endmodule

/* design/vga_scanout.sv */
// Display scanout on the scaled raster
// Sync and blank timing, buffer read addressing and colour expansion
`timescale 1ns/1ps

module vga_scanout import cam_pkg::*; (
    input  logic     clk_25_vga,
    input  logic     reset_global,
    input  logic     show_edge,
    output addr_t    scan_addr,
    input  pixel_t   buf1_data,
    input  luma_t    buf2_data,
    output addr_t    buf2_rd_addr,
    output vga_out_t vga
);

    logic [HCNT_W-1:0] h_cnt;
    logic [VCNT_W-1:0] v_cnt;
    logic              active;
    logic              hsync_raw;
    logic              vsync_raw;
    addr_t             raster_addr;
    logic              active_d;
    logic              hsync_d;
    logic              vsync_d;
    pixel_t            shown;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == HCNT_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == VCNT_W'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + VCNT_W'(1);
            end
        end else begin
            h_cnt <= h_cnt + HCNT_W'(1);
        end
    end

    assign active    = (h_cnt < HCNT_W'(IMG_W)) && (v_cnt < VCNT_W'(IMG_H));
    assign hsync_raw = !((h_cnt >= HCNT_W'(H_SYNC_START)) && (h_cnt < HCNT_W'(H_SYNC_END)));
    assign vsync_raw = !((v_cnt >= VCNT_W'(V_SYNC_START)) && (v_cnt < VCNT_W'(V_SYNC_END)));

    // Row-major address, parked at 0 outside the image
    assign raster_addr  = active ? addr_t'(v_cnt) * addr_t'(IMG_W) + addr_t'(h_cnt) : '0;
    assign scan_addr    = raster_addr;
    assign buf2_rd_addr = raster_addr;

    // Controls wait one cycle for the buffer read
    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end else begin
            active_d <= active;
            hsync_d  <= hsync_raw;
            vsync_d  <= vsync_raw;
        end
    end

    assign shown = show_edge ? '{r: buf2_data, g: buf2_data, b: buf2_data} : buf1_data;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            vga <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0, r: 8'h00, g: 8'h00, b: 8'h00};
        end else begin
            vga.hsync   <= hsync_d;
            vga.vsync   <= vsync_d;
            vga.blank_n <= active_d;
            vga.r       <= active_d ? {shown.r, shown.r} : 8'h00;
            vga.g       <= active_d ? {shown.g, shown.g} : 8'h00;
            vga.b       <= active_d ? {shown.b, shown.b} : 8'h00;
        end
    end

endmodule

/* design/edge_filter.sv */
// Edge pass from buffer 1 into buffer 2
// Sum of horizontal and vertical neighbor differences, clamped at 15
`timescale 1ns/1ps

module edge_filter import cam_pkg::*; (
    input  logic     clk_25_vga,
    input  logic     reset_global,
    input  logic     start,
    output logic     done,
    output addr_t    rd_addr,
    input  pixel_t   rd_data,
    output luma_wr_t wr
);

    logic           busy;
    logic           finished;
    logic [2:0]     step;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    addr_t          addr;
    logic           border;
    logic           pix_last;
    logic           pix_end;
    luma_t          left_q;
    luma_t          gx_q;
    luma_t          up_q;
    logic [4:0]     grad_sum;
    luma_t          grad;

    function automatic luma_t abs_diff(input luma_t a, input luma_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    assign border = (x == '0) || (x == X_W'(IMG_W - 1)) ||
                    (y == '0) || (y == Y_W'(IMG_H - 1));
    assign pix_last = (addr == addr_t'(IMG_PIXELS - 1));
    // Border pixels finish at once, interior ones after the fourth read returns
    assign pix_end  = busy && (border || step == 3'd4);

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            busy     <= 1'b0;
            finished <= 1'b0;
            step     <= '0;
            x        <= '0;
            y        <= '0;
            addr     <= '0;
        end else if (busy) begin
            if (!pix_end) begin
                step <= step + 3'd1;
            end else if (pix_last) begin
                busy     <= 1'b0;
                finished <= 1'b1;
            end else begin
                step <= '0;
                addr <= addr + addr_t'(1);
                if (x == X_W'(IMG_W - 1)) begin
                    x <= '0;
                    y <= y + Y_W'(1);
                end else begin
                    x <= x + X_W'(1);
                end
            end
        end else if (!start) begin
            finished <= 1'b0;
        end else if (!finished) begin
            busy <= 1'b1;
            step <= '0;
            x    <= '0;
            y    <= '0;
            addr <= '0;
        end
    end

    // Neighbor samples, each arriving one cycle after its address
    always_ff @(posedge clk_25_vga) begin
        if (step == 3'd1) begin
            left_q <= rd_data.r;
        end
        if (step == 3'd2) begin
            gx_q <= abs_diff(rd_data.r, left_q);
        end
        if (step == 3'd3) begin
            up_q <= rd_data.r;
        end
    end

    always_comb begin
        rd_addr = addr;
        if (!border) begin
            case (step)
                3'd0: rd_addr = addr - addr_t'(1);
                3'd1: rd_addr = addr + addr_t'(1);
                3'd2: rd_addr = addr - addr_t'(IMG_W);
                3'd3: rd_addr = addr + addr_t'(IMG_W);
                default: rd_addr = addr;
            endcase
        end
    end

    assign grad_sum = {1'b0, gx_q} + {1'b0, abs_diff(rd_data.r, up_q)};
    assign grad     = (grad_sum > 5'd15) ? 4'hF : grad_sum[3:0];

    assign wr   = '{en: pix_end, addr: addr, data: border ? luma_t'(0) : grad};
    assign done = pix_end && pix_last;

endmodule

/* design/gray_filter.sv */
// Grayscale pass over buffer 1
// Reads each pixel, writes (r + 2g + b) / 4 back into all three channels
`timescale 1ns/1ps

module gray_filter import cam_pkg::*; (
    input  logic    clk_25_vga,
    input  logic    reset_global,
    input  logic    start,
    output logic    done,
    output addr_t   rd_addr,
    input  pixel_t  rd_data,
    output pix_wr_t wr
);

    logic       busy;
    logic       phase;
    logic       finished;
    addr_t      addr;
    logic [5:0] gray_sum;
    luma_t      gray;

    // Two cycles per pixel: phase 0 reads, phase 1 writes
    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            busy     <= 1'b0;
            phase    <= 1'b0;
            finished <= 1'b0;
            addr     <= '0;
        end else if (busy) begin
            phase <= ~phase;
            if (phase) begin
                if (addr == addr_t'(IMG_PIXELS - 1)) begin
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end else begin
                    addr <= addr + addr_t'(1);
                end
            end
        end else if (!start) begin
            finished <= 1'b0;
        end else if (!finished) begin
            busy  <= 1'b1;
            phase <= 1'b0;
            addr  <= '0;
        end
    end

    assign gray_sum = {2'b00, rd_data.r} + {1'b0, rd_data.g, 1'b0} + {2'b00, rd_data.b};
    assign gray     = gray_sum[5:2];

    assign rd_addr = addr;
    assign wr      = '{en: busy && phase, addr: addr, data: '{r: gray, g: gray, b: gray}};
    assign done    = busy && phase && (addr == addr_t'(IMG_PIXELS - 1));

endmodule

/* design/frame_sequencer.sv */
// Mode sequencer for the camera pipeline
// Runs live, gray and edge passes and decides who owns each frame buffer
`timescale 1ns/1ps

module frame_sequencer import cam_pkg::*; (
    input  logic     clk_25_vga,
    input  logic     reset_global,
    input  logic     process_sw,
    output logic     frame_done,
    input  pixel_t   pix_in,
    input  logic     pix_valid,
    output logic     pix_ready,
    output logic     gray_start,
    input  logic     gray_done,
    output logic     edge_start,
    input  logic     edge_done,
    input  addr_t    gray_rd_addr,
    input  pix_wr_t  gray_wr,
    input  addr_t    edge_rd_addr,
    input  luma_wr_t edge_wr,
    input  addr_t    scan_addr,
    output pix_wr_t  buf1_wr,
    output addr_t    buf1_rd_addr,
    output luma_wr_t buf2_wr,
    output logic     show_edge
);

    seq_state_t state_current;
    seq_state_t state_next;
    addr_t      ingest_addr;
    logic       accept;

    assign pix_ready  = (state_current == LIVE);
    assign frame_done = (state_current == HOLD);
    assign gray_start = (state_current == GRAY);
    assign edge_start = (state_current == EDGE);
    assign show_edge  = (state_current == EDGE) || (state_current == HOLD);
    assign accept     = pix_valid && pix_ready;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state_current <= LIVE;
        end else begin
            state_current <= state_next;
        end
    end

    // Ingest address restarts for every new live session
    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            ingest_addr <= '0;
        end else if (state_current == HOLD && !process_sw) begin
            ingest_addr <= '0;
        end else if (accept) begin
            if (ingest_addr == addr_t'(IMG_PIXELS - 1)) begin
                ingest_addr <= '0;
            end else begin
                ingest_addr <= ingest_addr + addr_t'(1);
            end
        end
    end

    always_comb begin
        state_next = state_current;
        // Live video by default: ingest writes buffer 1, display reads it
        buf1_wr      = '{en: accept, addr: ingest_addr, data: pix_in};
        buf1_rd_addr = scan_addr;
        buf2_wr      = edge_wr;
        buf2_wr.en   = 1'b0;

        case (state_current)
            LIVE: begin
                if (process_sw) begin
                    state_next = GRAY;
                end
            end
            GRAY: begin
                buf1_wr      = gray_wr;
                buf1_rd_addr = gray_rd_addr;
                if (gray_done) begin
                    state_next = EDGE;
                end
            end
            EDGE: begin
                // Buffer 1 is read only, results land in buffer 2
                buf1_wr.en   = 1'b0;
                buf1_rd_addr = edge_rd_addr;
                buf2_wr      = edge_wr;
                if (edge_done) begin
                    state_next = HOLD;
                end
            end
            HOLD: begin
                buf1_wr.en = 1'b0;
                if (!process_sw) begin
                    state_next = LIVE;
                end
            end
            default: state_next = LIVE;
        endcase
    end

endmodule

/* design/frame_buffer.sv */
// Frame buffer
// Simple dual-port RAM of one frame, synchronous write and registered read
`timescale 1ns/1ps

module frame_buffer import cam_pkg::*; #(
    parameter type word_t = pixel_t
) (
    input  logic  clk_25_vga,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  word_t wr_data,
    input  addr_t rd_addr,
    output word_t rd_data
);

    word_t mem [IMG_PIXELS];

    always_ff @(posedge clk_25_vga) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data appears one cycle after the address
    always_ff @(posedge clk_25_vga) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/cam_pkg.sv */
// Camera frame pipeline shared definitions
// Image and raster sizes, pixel and buffer write types, sequencer modes
package cam_pkg;

    // Image geometry
    localparam int IMG_W      = 32;
    localparam int IMG_H      = 24;
    localparam int IMG_PIXELS = IMG_W * IMG_H;
    localparam int ADDR_W     = 10;
    localparam int X_W        = $clog2(IMG_W);
    localparam int Y_W        = $clog2(IMG_H);

    // Scaled display raster, sync pulses are active low
    localparam int H_TOTAL      = 40;
    localparam int V_TOTAL      = 28;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_END   = 36;
    localparam int V_SYNC_START = 25;
    localparam int V_SYNC_END   = 27;
    localparam int HCNT_W       = $clog2(H_TOTAL);
    localparam int VCNT_W       = $clog2(V_TOTAL);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [3:0] luma_t;

    // RGB444 pixel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pixel_t;

    // One write into buffer 1
    typedef struct packed {
        logic   en;
        addr_t  addr;
        pixel_t data;
    } pix_wr_t;

    // One write into buffer 2
    typedef struct packed {
        logic  en;
        addr_t addr;
        luma_t data;
    } luma_wr_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       blank_n;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } vga_out_t;

    typedef enum logic [1:0] {
        LIVE,
        GRAY,
        EDGE,
        HOLD
    } seq_state_t;

endpackage
